//--- hdl/opl3_slot_config.svh
// size and timing constants for the fm slot controller, included by its package and modules
`ifndef OPL3_SLOT_CONFIG_SVH
`define OPL3_SLOT_CONFIG_SVH

// two register banks, each with its own operators and channels
`define OPL3_NUM_BANKS 2

// operator slots in one bank
`define OPL3_OPS_PER_BANK 18

// two-operator channels in one bank
`define OPL3_CHANS_PER_BANK 9

// operator locations per bank with offsets 6, 7, 14 and 15 left unused
`define OPL3_OP_MEM_DEPTH 22

// clock cycles spent on each operator slot
`define OPL3_SLOT_CYCLES 2

`endif

//--- hdl/opl3_slot_pkg.sv
// index and register field types shared by every module of the fm slot controller
`default_nettype none

`include "opl3_slot_config.svh"

package opl3_slot_pkg;

    typedef logic [$clog2(`OPL3_NUM_BANKS)-1:0] bank_t;
    typedef logic [$clog2(`OPL3_OPS_PER_BANK)-1:0] op_num_t;
    typedef logic [$clog2(`OPL3_OP_MEM_DEPTH)-1:0] op_addr_t;
    typedef logic [$clog2(`OPL3_CHANS_PER_BANK)-1:0] chan_addr_t;

    typedef logic [7:0] reg_byte_t;
    typedef logic [2:0] ws_t;        // waveform select
    typedef logic [5:0] chan_high_t; // key-on, block, fnum[9:8]
    typedef logic [3:0] fb_cnt_t;    // feedback and connection
    typedef logic [5:0] conn_sel_t;  // bits 2:0 bank 0, bits 5:3 bank 1

    typedef enum logic [3:0] {
        grp_none,
        grp_20,
        grp_40,
        grp_60,
        grp_80,
        grp_e0,
        grp_a0,
        grp_b0,
        grp_c0
    } reg_group_t;

endpackage

`default_nettype wire

//--- hdl/reg_write_decode.sv
// wishbone classic write slave that sorts register writes into groups for the parameter memories
`timescale 1ns/100ps
`default_nettype none

module reg_write_decode (
    input wire clk,
    input wire reset,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_we,
    input wire [8:0] wb_adr,                  // bank in bit 8
    input wire opl3_slot_pkg::reg_byte_t wb_dat,
    output logic wb_ack,
    output logic wr_en,
    output opl3_slot_pkg::reg_group_t wr_group,
    output opl3_slot_pkg::bank_t wr_bank,
    output opl3_slot_pkg::op_addr_t wr_offset,
    output opl3_slot_pkg::reg_byte_t wr_data,
    output opl3_slot_pkg::conn_sel_t conn_sel
);
    import opl3_slot_pkg::*;

    logic req;
    logic conn_hit;       // pending write to the connection select
    reg_group_t group;

    assign req = wb_cyc && wb_stb && !wb_ack; // no wait states

    always_comb begin
        group = grp_none;
        if (wb_adr[7:0] >= 8'h20 && wb_adr[7:0] <= 8'h35) group = grp_20;
        if (wb_adr[7:0] >= 8'h40 && wb_adr[7:0] <= 8'h55) group = grp_40;
        if (wb_adr[7:0] >= 8'h60 && wb_adr[7:0] <= 8'h75) group = grp_60;
        if (wb_adr[7:0] >= 8'h80 && wb_adr[7:0] <= 8'h95) group = grp_80;
        if (wb_adr[7:0] >= 8'he0 && wb_adr[7:0] <= 8'hf5) group = grp_e0;
        if (wb_adr[7:0] >= 8'ha0 && wb_adr[7:0] <= 8'ha8) group = grp_a0;
        if (wb_adr[7:0] >= 8'hb0 && wb_adr[7:0] <= 8'hb8) group = grp_b0;
        if (wb_adr[7:0] >= 8'hc0 && wb_adr[7:0] <= 8'hc8) group = grp_c0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            wb_ack <= req;
            wr_en <= req && wb_we;     // reads are acked only
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wr_group <= group;
            wr_bank <= wb_adr[8];
            wr_offset <= wb_adr[4:0];
            wr_data <= wb_dat;
            conn_hit <= wb_adr == 9'h104;
        end
    end

    // lands together with the memory writes at the end of the ack cycle
    always_ff @(posedge clk) begin
        if (reset)
            conn_sel <= '0;
        else if (wr_en && conn_hit)
            conn_sel <= wr_data[5:0];
    end

endmodule

`default_nettype wire

//--- hdl/param_bank_mem.sv
// two-bank parameter memory, written from the register bus and read once per operator slot
`timescale 1ns/100ps
`default_nettype none

`include "opl3_slot_config.svh"

module param_bank_mem #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = `OPL3_OP_MEM_DEPTH
) (
    input wire clk,
    input wire reset,
    input wire wr_en,
    input wire opl3_slot_pkg::bank_t wr_bank,
    input wire [$clog2(DEPTH)-1:0] wr_addr,
    input var payload_t wr_data,
    input wire rd_en,
    input wire opl3_slot_pkg::bank_t rd_bank,
    input wire [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t rd_data
);
    payload_t mem [`OPL3_NUM_BANKS][DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < `OPL3_NUM_BANKS; b++)
                for (int i = 0; i < DEPTH; i++)
                    mem[b][i] <= '0;
            rd_data <= '0;
        end else begin
            if (wr_en)
                mem[wr_bank][wr_addr] <= wr_data;
            if (rd_en)
                rd_data <= mem[rd_bank][rd_addr]; // old value on a same-cycle write
        end
    end

endmodule

`default_nettype wire

//--- hdl/slot_sequencer.sv
// frame state machine that walks all 36 operator slots after each sample tick
`timescale 1ns/100ps
`default_nettype none

`include "opl3_slot_config.svh"

module slot_sequencer (
    input wire clk,
    input wire reset,
    input wire sample_tick,
    output logic slot_issue,
    output opl3_slot_pkg::bank_t slot_bank,
    output opl3_slot_pkg::op_num_t slot_op
);
    import opl3_slot_pkg::*;

    localparam int NUM_SLOTS = `OPL3_NUM_BANKS * `OPL3_OPS_PER_BANK;
    localparam int ST_W = $clog2(NUM_SLOTS + 1);
    localparam int CNT_W = $clog2(`OPL3_SLOT_CYCLES);

    logic [ST_W-1:0] state;   // 0 idle, 1..36 slot k+1
    logic [CNT_W-1:0] cyc_cnt;
    logic last_cycle;

    assign last_cycle = cyc_cnt == CNT_W'(`OPL3_SLOT_CYCLES - 1);
    assign slot_issue = state != '0 && cyc_cnt == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= '0;
            cyc_cnt <= '0;
        end else if (state == '0) begin
            cyc_cnt <= '0;
            if (sample_tick)
                state <= ST_W'(1);
        end else if (last_cycle) begin
            cyc_cnt <= '0;
            state <= (state == ST_W'(NUM_SLOTS)) ? '0 : state + 1'b1;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // bank 0 slots first, then bank 1
    always_comb begin
        slot_bank = bank_t'(state > ST_W'(`OPL3_OPS_PER_BANK));
        if (state == '0)
            slot_op = '0;
        else if (slot_bank != '0)
            slot_op = op_num_t'(state - ST_W'(`OPL3_OPS_PER_BANK + 1));
        else
            slot_op = op_num_t'(state - 1'b1);
    end

endmodule

`default_nettype wire

//--- hdl/param_fetch.sv
// maps each issued slot to its operator and channel locations and reads the parameter memories
`timescale 1ns/100ps
`default_nettype none

`include "opl3_slot_config.svh"

module param_fetch (
    input wire clk,
    input wire reset,
    input wire wr_en,
    input var opl3_slot_pkg::reg_group_t wr_group,
    input wire opl3_slot_pkg::bank_t wr_bank,
    input wire opl3_slot_pkg::op_addr_t wr_offset,
    input wire opl3_slot_pkg::reg_byte_t wr_data,
    input wire opl3_slot_pkg::conn_sel_t conn_sel,
    input wire slot_issue,
    input wire opl3_slot_pkg::bank_t slot_bank,
    input wire opl3_slot_pkg::op_num_t slot_op,
    output logic fetch_valid,
    output opl3_slot_pkg::bank_t fetch_bank,
    output opl3_slot_pkg::op_num_t fetch_op,
    output opl3_slot_pkg::reg_byte_t op_byte_20,
    output opl3_slot_pkg::reg_byte_t op_byte_40,
    output opl3_slot_pkg::reg_byte_t op_byte_60,
    output opl3_slot_pkg::reg_byte_t op_byte_80,
    output opl3_slot_pkg::ws_t op_ws,
    output opl3_slot_pkg::reg_byte_t fnum_low,
    output opl3_slot_pkg::chan_high_t chan_high,
    output opl3_slot_pkg::fb_cnt_t fb_cnt,
    output logic use_feedback
);
    import opl3_slot_pkg::*;

    localparam reg_group_t BYTE_GROUPS [4] = '{grp_20, grp_40, grp_60, grp_80};

    op_addr_t op_addr;
    chan_addr_t chan_addr;
    chan_addr_t wr_chan;
    logic [1:0] op_mod3;
    logic [2:0] sel_idx;      // conn_sel bit for this pair
    logic paired;             // four-operator pairing active
    logic fb_next;
    reg_byte_t op_bytes [4];

    assign wr_chan = wr_offset[3:0];

    always_comb begin
        op_mod3 = 2'(slot_op % 5'd3);
        sel_idx = {1'b0, op_mod3} + (slot_bank != '0 ? 3'd3 : 3'd0);
        paired = conn_sel[sel_idx];

        if (slot_op < 5'd6)
            op_addr = slot_op;
        else if (slot_op < 5'd12)
            op_addr = slot_op + 5'd2;
        else
            op_addr = slot_op + 5'd4;

        if (slot_op < 5'd6)
            chan_addr = chan_addr_t'(op_mod3);
        else if (slot_op < 5'd12)
            chan_addr = paired ? chan_addr_t'(op_mod3) : chan_addr_t'(op_mod3) + 4'd3;
        else
            chan_addr = chan_addr_t'(op_mod3) + 4'd6;

        if (slot_op < 5'd3 || slot_op >= 5'd12)
            fb_next = 1'b1;
        else if (slot_op >= 5'd6 && slot_op < 5'd9)
            fb_next = !paired; // second half of a pair gets no feedback
        else
            fb_next = 1'b0;
    end

    for (genvar g = 0; g < 4; g++) begin : g_byte_mem
        param_bank_mem #(.payload_t(reg_byte_t), .DEPTH(`OPL3_OP_MEM_DEPTH)) u_mem (
            .clk, .reset,
            .wr_en(wr_en && wr_group == BYTE_GROUPS[g]),
            .wr_bank, .wr_addr(wr_offset), .wr_data,
            .rd_en(slot_issue), .rd_bank(slot_bank), .rd_addr(op_addr),
            .rd_data(op_bytes[g])
        );
    end

    assign op_byte_20 = op_bytes[0];
    assign op_byte_40 = op_bytes[1];
    assign op_byte_60 = op_bytes[2];
    assign op_byte_80 = op_bytes[3];

    param_bank_mem #(.payload_t(ws_t), .DEPTH(`OPL3_OP_MEM_DEPTH)) u_ws_mem (
        .clk, .reset,
        .wr_en(wr_en && wr_group == grp_e0),
        .wr_bank, .wr_addr(wr_offset), .wr_data(wr_data[2:0]),
        .rd_en(slot_issue), .rd_bank(slot_bank), .rd_addr(op_addr),
        .rd_data(op_ws)
    );

    param_bank_mem #(.payload_t(reg_byte_t), .DEPTH(`OPL3_CHANS_PER_BANK)) u_fnum_mem (
        .clk, .reset,
        .wr_en(wr_en && wr_group == grp_a0),
        .wr_bank, .wr_addr(wr_chan), .wr_data,
        .rd_en(slot_issue), .rd_bank(slot_bank), .rd_addr(chan_addr),
        .rd_data(fnum_low)
    );

    param_bank_mem #(.payload_t(chan_high_t), .DEPTH(`OPL3_CHANS_PER_BANK)) u_high_mem (
        .clk, .reset,
        .wr_en(wr_en && wr_group == grp_b0),
        .wr_bank, .wr_addr(wr_chan), .wr_data(wr_data[5:0]),
        .rd_en(slot_issue), .rd_bank(slot_bank), .rd_addr(chan_addr),
        .rd_data(chan_high)
    );

    param_bank_mem #(.payload_t(fb_cnt_t), .DEPTH(`OPL3_CHANS_PER_BANK)) u_fb_mem (
        .clk, .reset,
        .wr_en(wr_en && wr_group == grp_c0),
        .wr_bank, .wr_addr(wr_chan), .wr_data(wr_data[3:0]),
        .rd_en(slot_issue), .rd_bank(slot_bank), .rd_addr(chan_addr),
        .rd_data(fb_cnt)
    );

    always_ff @(posedge clk) begin
        if (reset)
            fetch_valid <= 1'b0;
        else
            fetch_valid <= slot_issue; // matches the read latency
    end

    always_ff @(posedge clk) begin
        if (slot_issue) begin
            fetch_bank <= slot_bank;
            fetch_op <= slot_op;
            use_feedback <= fb_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/slot_result.sv
// output register stage for the slot parameter stream, with the end-of-frame pulse
`timescale 1ns/100ps
`default_nettype none

`include "opl3_slot_config.svh"

module slot_result (
    input wire clk,
    input wire reset,
    input wire fetch_valid,
    input wire opl3_slot_pkg::bank_t fetch_bank,
    input wire opl3_slot_pkg::op_num_t fetch_op,
    input wire opl3_slot_pkg::reg_byte_t fetch_byte_20,
    input wire opl3_slot_pkg::reg_byte_t fetch_byte_40,
    input wire opl3_slot_pkg::reg_byte_t fetch_byte_60,
    input wire opl3_slot_pkg::reg_byte_t fetch_byte_80,
    input wire opl3_slot_pkg::ws_t fetch_ws,
    input wire opl3_slot_pkg::reg_byte_t fetch_fnum_low,
    input wire opl3_slot_pkg::chan_high_t fetch_chan_high,
    input wire opl3_slot_pkg::fb_cnt_t fetch_fb_cnt,
    input wire fetch_use_feedback,
    output logic out_valid,
    output opl3_slot_pkg::bank_t out_bank,
    output opl3_slot_pkg::op_num_t out_op,
    output opl3_slot_pkg::reg_byte_t op_byte_20,
    output opl3_slot_pkg::reg_byte_t op_byte_40,
    output opl3_slot_pkg::reg_byte_t op_byte_60,
    output opl3_slot_pkg::reg_byte_t op_byte_80,
    output opl3_slot_pkg::ws_t op_ws,
    output opl3_slot_pkg::reg_byte_t fnum_low,
    output opl3_slot_pkg::chan_high_t chan_high,
    output opl3_slot_pkg::fb_cnt_t fb_cnt,
    output logic use_feedback,
    output logic frame_done
);
    import opl3_slot_pkg::*;

    logic last_slot;

    assign last_slot = out_bank == bank_t'(`OPL3_NUM_BANKS - 1)
        && out_op == op_num_t'(`OPL3_OPS_PER_BANK - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            out_valid <= fetch_valid;
            frame_done <= out_valid && last_slot; // one cycle after the final slot
        end
    end

    // record held stable until the next slot
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            out_bank <= fetch_bank;
            out_op <= fetch_op;
            op_byte_20 <= fetch_byte_20;
            op_byte_40 <= fetch_byte_40;
            op_byte_60 <= fetch_byte_60;
            op_byte_80 <= fetch_byte_80;
            op_ws <= fetch_ws;
            fnum_low <= fetch_fnum_low;
            chan_high <= fetch_chan_high;
            fb_cnt <= fetch_fb_cnt;
            use_feedback <= fetch_use_feedback;
        end
    end

endmodule

`default_nettype wire

//--- hdl/operator_slot_control.sv
// top level of the fm slot controller, joining register decode, slot fetch and result stages
`timescale 1ns/100ps
`default_nettype none

module operator_slot_control (
    input wire clk,
    input wire reset,
    input wire sample_tick,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_we,
    input wire [8:0] wb_adr,
    input wire opl3_slot_pkg::reg_byte_t wb_dat,
    output logic wb_ack,
    output logic out_valid,
    output opl3_slot_pkg::bank_t out_bank,
    output opl3_slot_pkg::op_num_t out_op,
    output opl3_slot_pkg::reg_byte_t op_byte_20,
    output opl3_slot_pkg::reg_byte_t op_byte_40,
    output opl3_slot_pkg::reg_byte_t op_byte_60,
    output opl3_slot_pkg::reg_byte_t op_byte_80,
    output opl3_slot_pkg::ws_t op_ws,
    output opl3_slot_pkg::reg_byte_t fnum_low,
    output opl3_slot_pkg::chan_high_t chan_high,
    output opl3_slot_pkg::fb_cnt_t fb_cnt,
    output logic use_feedback,
    output logic frame_done
);
    import opl3_slot_pkg::*;

    logic wr_en;
    reg_group_t wr_group;
    bank_t wr_bank;
    op_addr_t wr_offset;
    reg_byte_t wr_data;
    conn_sel_t conn_sel;
    logic slot_issue;
    bank_t slot_bank;
    op_num_t slot_op;
    logic fetch_valid;
    bank_t fetch_bank;
    op_num_t fetch_op;
    reg_byte_t fetch_byte_20, fetch_byte_40, fetch_byte_60, fetch_byte_80;
    ws_t fetch_ws;
    reg_byte_t fetch_fnum_low;
    chan_high_t fetch_chan_high;
    fb_cnt_t fetch_fb_cnt;
    logic fetch_use_feedback;

    reg_write_decode u_decode (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .wb_ack,
        .wr_en, .wr_group, .wr_bank, .wr_offset, .wr_data, .conn_sel
    );

    slot_sequencer u_sequencer (
        .clk, .reset, .sample_tick, .slot_issue, .slot_bank, .slot_op
    );

    param_fetch u_fetch (
        .clk, .reset, .wr_en, .wr_group, .wr_bank, .wr_offset, .wr_data, .conn_sel,
        .slot_issue, .slot_bank, .slot_op,
        .fetch_valid, .fetch_bank, .fetch_op,
        .op_byte_20(fetch_byte_20), .op_byte_40(fetch_byte_40),
        .op_byte_60(fetch_byte_60), .op_byte_80(fetch_byte_80),
        .op_ws(fetch_ws), .fnum_low(fetch_fnum_low), .chan_high(fetch_chan_high),
        .fb_cnt(fetch_fb_cnt), .use_feedback(fetch_use_feedback)
    );

    slot_result u_result (
        .clk, .reset, .fetch_valid, .fetch_bank, .fetch_op,
        .fetch_byte_20, .fetch_byte_40, .fetch_byte_60, .fetch_byte_80,
        .fetch_ws, .fetch_fnum_low, .fetch_chan_high, .fetch_fb_cnt, .fetch_use_feedback,
        .out_valid, .out_bank, .out_op,
        .op_byte_20, .op_byte_40, .op_byte_60, .op_byte_80,
        .op_ws, .fnum_low, .chan_high, .fb_cnt, .use_feedback, .frame_done
    );

endmodule

`default_nettype wire

//--- verification/operator_slot_control_tb.sv
// testbench for the fm slot controller, drives register writes and frames and checks every slot
`timescale 1ns/100ps
`default_nettype none

`include "opl3_slot_config.svh"

module operator_slot_control_tb;
    import opl3_slot_pkg::*;

    localparam int NUM_SLOTS = `OPL3_NUM_BANKS * `OPL3_OPS_PER_BANK;
    localparam int FRAME_CYCLES = 80;      // 74 active cycles plus idle gap
    localparam int MAX_FRAMES = 40;
    localparam int WRITE_CYCLES = 2800;    // about 900 bus accesses of 3 cycles
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES + WRITE_CYCLES;
    localparam int OP_BASE [5] = '{'h20, 'h40, 'h60, 'h80, 'he0};
    localparam int CHAN_BASE [3] = '{'ha0, 'hb0, 'hc0};

    typedef struct packed {
        logic [7:0] b20;
        logic [7:0] b40;
        logic [7:0] b60;
        logic [7:0] b80;
        logic [2:0] ws;
        logic [7:0] fnum;
        logic [5:0] high;
        logic [3:0] fb;
        logic use_fb;
    } slot_rec_t;

    logic clk = 1'b0;
    logic reset;
    logic sample_tick;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [8:0] wb_adr;
    reg_byte_t wb_dat;
    logic wb_ack;
    logic out_valid;
    bank_t out_bank;
    op_num_t out_op;
    reg_byte_t op_byte_20, op_byte_40, op_byte_60, op_byte_80;
    ws_t op_ws;
    reg_byte_t fnum_low;
    chan_high_t chan_high;
    fb_cnt_t fb_cnt;
    logic use_feedback;
    logic frame_done;

    // shadow copy of everything the DUT keeps
    logic [7:0] op_regs [5][`OPL3_NUM_BANKS][`OPL3_OP_MEM_DEPTH];
    logic [7:0] chan_regs [3][`OPL3_NUM_BANKS][`OPL3_CHANS_PER_BANK];
    logic [5:0] conn_shadow;

    integer seed = 32'h716c_536e;
    int errors, slots_checked, frames_done, frames_started, req_count, ack_count;
    int cyc, tick_cyc, slot_idx;
    bit frame_active, done_due, ack_prev;

    operator_slot_control dut (
        .clk, .reset, .sample_tick, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .wb_ack,
        .out_valid, .out_bank, .out_op, .op_byte_20, .op_byte_40, .op_byte_60, .op_byte_80,
        .op_ws, .fnum_low, .chan_high, .fb_cnt, .use_feedback, .frame_done
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cyc);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // expected record from the address, channel and feedback rules
    function automatic slot_rec_t expected_record(input int bank, input int op);
        slot_rec_t rec;
        int op_loc;
        int chan;
        logic pair;
        pair = conn_shadow[3 * bank + op % 3];
        if (op < 6)
            op_loc = op;
        else if (op < 12)
            op_loc = op + 2;
        else
            op_loc = op + 4;
        if (op < 6)
            chan = op % 3;
        else if (op < 12)
            chan = pair ? op % 3 : 3 + op % 3; // four-op pair shares the first channel
        else
            chan = 6 + op % 3;
        rec.b20 = op_regs[0][bank][op_loc];
        rec.b40 = op_regs[1][bank][op_loc];
        rec.b60 = op_regs[2][bank][op_loc];
        rec.b80 = op_regs[3][bank][op_loc];
        rec.ws = op_regs[4][bank][op_loc][2:0];
        rec.fnum = chan_regs[0][bank][chan];
        rec.high = chan_regs[1][bank][chan][5:0];
        rec.fb = chan_regs[2][bank][chan][3:0];
        if (op < 3 || op >= 12)
            rec.use_fb = 1'b1;
        else if (op >= 6 && op < 9)
            rec.use_fb = !pair;
        else
            rec.use_fb = 1'b0;
        return rec;
    endfunction

    function automatic void shadow_write(input logic [8:0] adr, input logic [7:0] dat);
        int bank;
        int ra;
        int g;
        bank = int'(adr[8]);
        ra = int'(adr[7:0]);
        for (g = 0; g < 5; g++)
            if (ra >= OP_BASE[g] && ra < OP_BASE[g] + `OPL3_OP_MEM_DEPTH)
                op_regs[g][bank][ra - OP_BASE[g]] = dat;
        for (g = 0; g < 3; g++)
            if (ra >= CHAN_BASE[g] && ra < CHAN_BASE[g] + `OPL3_CHANS_PER_BANK)
                chan_regs[g][bank][ra - CHAN_BASE[g]] = dat;
        if (adr == 9'h104)
            conn_shadow = dat[5:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h (slot %0d)", name, got, exp, slot_idx);
        end
    endtask

    // one wishbone classic cycle held until ack
    task automatic bus_access(input logic [8:0] adr, input logic [7:0] dat, input logic we);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat <= dat;
        req_count++;
        do @(negedge clk); while (wb_ack !== 1'b1);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        if (we)
            shadow_write(adr, dat);
    endtask

    task automatic run_frame(input bit extra_tick);
        int start;
        start = frames_done;
        frames_started++;
        @(posedge clk);
        sample_tick <= 1'b1;
        @(posedge clk);
        sample_tick <= 1'b0;
        if (extra_tick) begin
            repeat (20) @(posedge clk);
            sample_tick <= 1'b1;   // lands mid-frame
            @(posedge clk);
            sample_tick <= 1'b0;
        end
        while (frames_done == start) @(negedge clk);
        repeat (4) @(posedge clk);
    endtask

    // compare process sampling on the falling edge
    always @(negedge clk) begin
        slot_rec_t exp_rec;
        if (!reset) begin
            if (wb_ack) begin
                ack_count++;
                if (ack_prev) begin
                    errors++;
                    $display("wb_ack stayed high for more than one cycle");
                end
            end
            ack_prev = wb_ack;
            if (done_due) begin
                check_value("frame_done", 32'(frame_done), 32'd1);
                done_due = 1'b0;
                frame_active = 1'b0;
                frames_done++;
            end else if (frame_done) begin
                errors++;
                $display("frame_done pulsed without a final slot before it");
            end
            if (sample_tick && !frame_active) begin
                frame_active = 1'b1;
                tick_cyc = cyc;
                slot_idx = 0;
            end
            if (out_valid) begin
                if (!frame_active || slot_idx >= NUM_SLOTS) begin
                    errors++;
                    $display("out_valid seen while no frame was running");
                end else begin
                    exp_rec = expected_record(slot_idx / `OPL3_OPS_PER_BANK,
                                              slot_idx % `OPL3_OPS_PER_BANK);
                    check_value("out_valid cycle", cyc - tick_cyc, 3 + 2 * slot_idx);
                    check_value("out_bank", 32'(out_bank), slot_idx / `OPL3_OPS_PER_BANK);
                    check_value("out_op", 32'(out_op), slot_idx % `OPL3_OPS_PER_BANK);
                    check_value("op_byte_20", 32'(op_byte_20), 32'(exp_rec.b20));
                    check_value("op_byte_40", 32'(op_byte_40), 32'(exp_rec.b40));
                    check_value("op_byte_60", 32'(op_byte_60), 32'(exp_rec.b60));
                    check_value("op_byte_80", 32'(op_byte_80), 32'(exp_rec.b80));
                    check_value("op_ws", 32'(op_ws), 32'(exp_rec.ws));
                    check_value("fnum_low", 32'(fnum_low), 32'(exp_rec.fnum));
                    check_value("chan_high", 32'(chan_high), 32'(exp_rec.high));
                    check_value("fb_cnt", 32'(fb_cnt), 32'(exp_rec.fb));
                    check_value("use_feedback", 32'(use_feedback), 32'(exp_rec.use_fb));
                    slots_checked++;
                    slot_idx++;
                    if (slot_idx == NUM_SLOTS)
                        done_due = 1'b1;
                end
            end
        end
    end

    initial begin
        int g, b, off, n;
        reset = 1'b1;
        sample_tick = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        conn_shadow = '0;
        for (g = 0; g < 5; g++)
            for (b = 0; b < `OPL3_NUM_BANKS; b++)
                for (off = 0; off < `OPL3_OP_MEM_DEPTH; off++)
                    op_regs[g][b][off] = '0;
        for (g = 0; g < 3; g++)
            for (b = 0; b < `OPL3_NUM_BANKS; b++)
                for (off = 0; off < `OPL3_CHANS_PER_BANK; off++)
                    chan_regs[g][b][off] = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        run_frame(1'b0);                   // all zero after reset

        for (g = 0; g < 5; g++)            // all operator groups including the skipped offsets
            for (b = 0; b < `OPL3_NUM_BANKS; b++)
                for (off = 0; off < `OPL3_OP_MEM_DEPTH; off++)
                    bus_access(9'(b * 256 + OP_BASE[g] + off), rand_byte(), 1'b1);
        run_frame(1'b0);

        for (g = 0; g < 3; g++)            // channel groups while still unpaired
            for (b = 0; b < `OPL3_NUM_BANKS; b++)
                for (off = 0; off < `OPL3_CHANS_PER_BANK; off++)
                    bus_access(9'(b * 256 + CHAN_BASE[g] + off), rand_byte(), 1'b1);
        run_frame(1'b0);

        bus_access(9'h004, 8'hff, 1'b1);   // bank 0 address 0x04 has no effect
        run_frame(1'b0);
        for (n = 0; n < 6; n++) begin
            bus_access(9'h104, rand_byte(), 1'b1);
            run_frame(1'b0);
        end
        bus_access(9'h104, 8'h3f, 1'b1);
        run_frame(1'b0);

        bus_access(9'h125, rand_byte(), 1'b0); // read cycle that is acked and ignored
        run_frame(1'b1);

        repeat (4) @(posedge clk);
        if (ack_count != req_count) begin
            errors++;
            $display("bus requests and acks differ: %0d requests, %0d acks",
                     req_count, ack_count);
        end
        if (slots_checked != NUM_SLOTS * frames_started || frames_done != frames_started) begin
            errors++;
            $display("frames did not all complete with %0d slots each", NUM_SLOTS);
        end
        $display("errors %0d, slots %0d, frames %0d, bus requests %0d, acks %0d",
                 errors, slots_checked, frames_done, req_count, ack_count);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- operator_slot_control.f
+incdir+hdl
hdl/opl3_slot_pkg.sv
hdl/reg_write_decode.sv
hdl/param_bank_mem.sv
hdl/slot_sequencer.sv
hdl/param_fetch.sv
hdl/slot_result.sv
hdl/operator_slot_control.sv
verification/operator_slot_control_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := operator_slot_control_tb
FILELIST   := operator_slot_control.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
